//--- common/hazard_pkg.sv
package hazard_pkg;

    typedef logic [3:0] reg_idx_t;

    typedef logic [3:0] csr_idx_t;

    // compressed csr selectors
    localparam csr_idx_t MTVEC   = 4'h1;
    localparam csr_idx_t MEPC    = 4'h2;
    localparam csr_idx_t MCAUSE  = 4'h3;
    localparam csr_idx_t MSTATUS = 4'h4;

    typedef enum logic [2:0] {
        CD_NONE     = 3'b000,
        CD_BRANCHES = 3'b001,
        CD_JALR     = 3'b010,
        CD_ECALL    = 3'b011,
        CD_MRET     = 3'b100
    } cd_ctrl_e;

    typedef enum logic [3:0] {
        WB_NONE   = 4'b0000,
        WB_EXE    = 4'b0001,
        WB_MEM    = 4'b0010,
        WB_IMM    = 4'b0011,
        WB_SNPC   = 4'b0100,
        WB_CSRRW  = 4'b0101,
        WB_CSRRS  = 4'b0110,
        WB_CSRRWI = 4'b0111,
        WB_ECALL  = 4'b1000
    } wb_ctrl_e;

    // EXE, MEM and WB
    localparam int NUM_STAGES_DEFAULT = 3;

    function automatic logic wb_rd_write(wb_ctrl_e wb);
        logic hit;
        hit = (wb == WB_EXE)   || (wb == WB_MEM)   || (wb == WB_IMM) ||
              (wb == WB_SNPC)  || (wb == WB_CSRRW) || (wb == WB_CSRRS) ||
              (wb == WB_CSRRWI);
        return hit;
    endfunction

    function automatic logic wb_csr_write(wb_ctrl_e wb);
        logic hit;
        hit = (wb == WB_CSRRW) || (wb == WB_CSRRS) || (wb == WB_CSRRWI);
        return hit;
    endfunction

    // ecall writes mepc and mcause at wb
    function automatic logic wb_ecall_write(wb_ctrl_e wb);
        logic hit;
        hit = (wb == WB_ECALL);
        return hit;
    endfunction

endpackage

//--- hdl/read_demand_decode.sv
`timescale 1ns/1ps

module read_demand_decode (
    input  logic                 id_valid,
    input  hazard_pkg::cd_ctrl_e id_cd_ctrl,
    input  hazard_pkg::wb_ctrl_e id_wb_ctrl,
    output logic                 rs1_read,
    output logic                 rs2_read,
    output logic                 mtvec_read,
    output logic                 mepc_read,
    output logic                 rd_write,
    output logic                 csr_write,
    output logic                 ecall_write
);

    import hazard_pkg::*;

    always_comb begin
        rs1_read   = 1'b0;
        rs2_read   = 1'b0;
        mtvec_read = 1'b0;
        mepc_read  = 1'b0;
        if (id_valid) begin
            case (id_cd_ctrl)
                CD_BRANCHES: begin
                    rs1_read = 1'b1;
                    rs2_read = 1'b1;
                end
                CD_JALR: begin
                    rs1_read = 1'b1;   // target base only
                end
                CD_ECALL: begin
                    mtvec_read = 1'b1; // trap vector
                end
                CD_MRET: begin
                    mepc_read = 1'b1;
                end
                default: begin
                    rs1_read   = 1'b0;
                    rs2_read   = 1'b0;
                    mtvec_read = 1'b0;
                    mepc_read  = 1'b0;
                end
            endcase
        end
    end

    // write intents, qualified later at issue
    always_comb begin
        rd_write    = wb_rd_write(id_wb_ctrl);
        csr_write   = wb_csr_write(id_wb_ctrl);
        ecall_write = wb_ecall_write(id_wb_ctrl);
    end

endmodule

//--- hdl/writer_slot.sv
`timescale 1ns/1ps

module writer_slot (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_rd_write,
    input  logic                 in_csr_write,
    input  logic                 in_ecall_write,
    input  hazard_pkg::reg_idx_t in_rd,
    input  hazard_pkg::csr_idx_t in_csr,
    input  logic                 rs1_read,
    input  logic                 rs2_read,
    input  logic                 mtvec_read,
    input  logic                 mepc_read,
    input  hazard_pkg::reg_idx_t id_rs1,
    input  hazard_pkg::reg_idx_t id_rs2,
    input  hazard_pkg::csr_idx_t id_csr,
    output logic                 rd_write,
    output logic                 csr_write,
    output logic                 ecall_write,
    output hazard_pkg::reg_idx_t rd,
    output hazard_pkg::csr_idx_t csr,
    output logic                 conflict
);

    import hazard_pkg::*;

    logic rs1_hit;
    logic rs2_hit;
    logic csr_hit;
    logic ecall_hit;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_write    <= 1'b0;
            csr_write   <= 1'b0;
            ecall_write <= 1'b0;
            rd          <= '0;
            csr         <= '0;
        end else begin
            rd_write    <= in_rd_write;
            csr_write   <= in_csr_write;
            ecall_write <= in_ecall_write;
            rd          <= in_rd;
            csr         <= in_csr;
        end
    end

    // ecall and mret read fixed csrs
    always_comb begin
        rs1_hit   = rs1_read && rd_write && (rd == id_rs1);
        rs2_hit   = rs2_read && rd_write && (rd == id_rs2);
        csr_hit   = (mtvec_read && csr_write && (csr == MTVEC)) ||
                    (mepc_read && csr_write && (csr == MEPC));
        ecall_hit = mepc_read && ecall_write;   // ecall rewrites mepc
        conflict  = rs1_hit || rs2_hit || csr_hit || ecall_hit;
    end

endmodule

//--- hdl/stall_merge.sv
`timescale 1ns/1ps

module stall_merge #(
    parameter int NUM_STAGES = 3
) (
    input  logic [NUM_STAGES-1:0] conflict_vec,
    input  logic                  id_valid,
    input  logic                  rd_write,
    input  logic                  csr_write,
    input  logic                  ecall_write,
    input  hazard_pkg::reg_idx_t  id_rd,
    input  hazard_pkg::csr_idx_t  id_csr,
    output logic                  id_ready,
    output logic                  issue_rd_write,
    output logic                  issue_csr_write,
    output logic                  issue_ecall_write,
    output hazard_pkg::reg_idx_t  issue_rd,
    output hazard_pkg::csr_idx_t  issue_csr
);

    logic issue;

    // demands are zero without id_valid, so ready stays high then
    assign id_ready = ~|conflict_vec;
    assign issue    = id_valid && id_ready;

    always_comb begin
        if (issue) begin
            issue_rd_write    = rd_write;
            issue_csr_write   = csr_write;
            issue_ecall_write = ecall_write;
            issue_rd          = id_rd;
            issue_csr         = id_csr;
        end else begin
            issue_rd_write    = 1'b0;   // bubble
            issue_csr_write   = 1'b0;
            issue_ecall_write = 1'b0;
            issue_rd          = '0;
            issue_csr         = '0;
        end
    end

endmodule

//--- hdl/hazard_detector.sv
`timescale 1ns/1ps

module hazard_detector #(
    parameter int NUM_STAGES = hazard_pkg::NUM_STAGES_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 id_valid,
    input  hazard_pkg::cd_ctrl_e id_cd_ctrl,
    input  hazard_pkg::wb_ctrl_e id_wb_ctrl,
    input  hazard_pkg::reg_idx_t id_rd,
    input  hazard_pkg::reg_idx_t id_rs1,
    input  hazard_pkg::reg_idx_t id_rs2,
    input  hazard_pkg::csr_idx_t id_csr,
    output logic                 id_ready
);

    import hazard_pkg::*;

    logic rs1_read;
    logic rs2_read;
    logic mtvec_read;
    logic mepc_read;
    logic rd_write;
    logic csr_write;
    logic ecall_write;

    // entry 0 is the issue record, entry k+1 the output of slot k
    logic     chain_rd_write    [0:NUM_STAGES];
    logic     chain_csr_write   [0:NUM_STAGES];
    logic     chain_ecall_write [0:NUM_STAGES];
    reg_idx_t chain_rd          [0:NUM_STAGES];
    csr_idx_t chain_csr         [0:NUM_STAGES];

    logic [NUM_STAGES-1:0] conflict_vec;

    read_demand_decode u_decode (
        .id_valid    (id_valid),
        .id_cd_ctrl  (id_cd_ctrl),
        .id_wb_ctrl  (id_wb_ctrl),
        .rs1_read    (rs1_read),
        .rs2_read    (rs2_read),
        .mtvec_read  (mtvec_read),
        .mepc_read   (mepc_read),
        .rd_write    (rd_write),
        .csr_write   (csr_write),
        .ecall_write (ecall_write)
    );

    genvar k;
    generate
        for (k = 0; k < NUM_STAGES; k++) begin : g_slot
            writer_slot u_slot (
                .clk            (clk),
                .rst_n          (rst_n),
                .in_rd_write    (chain_rd_write[k]),
                .in_csr_write   (chain_csr_write[k]),
                .in_ecall_write (chain_ecall_write[k]),
                .in_rd          (chain_rd[k]),
                .in_csr         (chain_csr[k]),
                .rs1_read       (rs1_read),
                .rs2_read       (rs2_read),
                .mtvec_read     (mtvec_read),
                .mepc_read      (mepc_read),
                .id_rs1         (id_rs1),
                .id_rs2         (id_rs2),
                .id_csr         (id_csr),
                .rd_write       (chain_rd_write[k+1]),
                .csr_write      (chain_csr_write[k+1]),
                .ecall_write    (chain_ecall_write[k+1]),
                .rd             (chain_rd[k+1]),
                .csr            (chain_csr[k+1]),
                .conflict       (conflict_vec[k])
            );
        end
    endgenerate

    stall_merge #(
        .NUM_STAGES (NUM_STAGES)
    ) u_merge (
        .conflict_vec      (conflict_vec),
        .id_valid          (id_valid),
        .rd_write          (rd_write),
        .csr_write         (csr_write),
        .ecall_write       (ecall_write),
        .id_rd             (id_rd),
        .id_csr            (id_csr),
        .id_ready          (id_ready),
        .issue_rd_write    (chain_rd_write[0]),
        .issue_csr_write   (chain_csr_write[0]),
        .issue_ecall_write (chain_ecall_write[0]),
        .issue_rd          (chain_rd[0]),
        .issue_csr         (chain_csr[0])
    );

endmodule

//--- bench/hazard_detector_properties.sv
`timescale 1ns/1ps

module hazard_detector_properties #(
    parameter int NUM_STAGES = 3
) (
    input logic clk,
    input logic rst_n,
    input logic id_valid,
    input logic id_ready
);

    int low_run;  // consecutive cycles with id_ready low

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            low_run <= 0;
        end else if (id_ready) begin
            low_run <= 0;
        end else begin
            low_run <= low_run + 1;
        end
    end

    ready_when_idle: assert property (@(posedge clk) disable iff (!rst_n)
        !id_valid |-> id_ready)
        else $error("id_ready low while id_valid is low");

    ready_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(id_ready))
        else $error("id_ready is unknown");

    // a reader can only wait for writers already in the chain
    stall_bounded: assert property (@(posedge clk) disable iff (!rst_n)
        (low_run >= NUM_STAGES) |-> id_ready)
        else $error("id_ready low for more than %0d cycles", NUM_STAGES);

endmodule

bind hazard_detector hazard_detector_properties #(
    .NUM_STAGES (NUM_STAGES)
) u_properties (
    .clk      (clk),
    .rst_n    (rst_n),
    .id_valid (id_valid),
    .id_ready (id_ready)
);

//--- bench/hazard_detector_tb.sv
`timescale 1ns/1ps

module hazard_detector_tb;

    import hazard_pkg::*;

    localparam int NUM_STAGES  = 3;
    localparam int CYCLE_LIMIT = 2000;  // directed ~120 plus 200 randoms at up to 4 cycles

    logic     clk;
    logic     rst_n;
    logic     id_valid;
    cd_ctrl_e id_cd_ctrl;
    wb_ctrl_e id_wb_ctrl;
    reg_idx_t id_rd;
    reg_idx_t id_rs1;
    reg_idx_t id_rs2;
    csr_idx_t id_csr;
    logic     id_ready;

    int seed;
    int errors;
    int checks;
    int tests;
    int cycles;

    // reference model of the pending writers
    logic     mdl_rd_write    [NUM_STAGES];
    logic     mdl_csr_write   [NUM_STAGES];
    logic     mdl_ecall_write [NUM_STAGES];
    reg_idx_t mdl_rd          [NUM_STAGES];
    csr_idx_t mdl_csr         [NUM_STAGES];
    logic     need_rs1;
    logic     need_rs2;
    logic     need_mtvec;
    logic     need_mepc;
    logic     exp_ready;

    hazard_detector #(
        .NUM_STAGES (NUM_STAGES)
    ) UUT (
        .clk        (clk),
        .rst_n      (rst_n),
        .id_valid   (id_valid),
        .id_cd_ctrl (id_cd_ctrl),
        .id_wb_ctrl (id_wb_ctrl),
        .id_rd      (id_rd),
        .id_rs1     (id_rs1),
        .id_rs2     (id_rs2),
        .id_csr     (id_csr),
        .id_ready   (id_ready)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    function automatic logic writes_rd(wb_ctrl_e wb);
        case (wb)
            WB_EXE, WB_MEM, WB_IMM, WB_SNPC, WB_CSRRW, WB_CSRRS, WB_CSRRWI: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic writes_csr(wb_ctrl_e wb);
        return (wb == WB_CSRRW) || (wb == WB_CSRRS) || (wb == WB_CSRRWI);
    endfunction

    always_comb begin
        need_rs1   = id_valid && ((id_cd_ctrl == CD_BRANCHES) || (id_cd_ctrl == CD_JALR));
        need_rs2   = id_valid && (id_cd_ctrl == CD_BRANCHES);
        need_mtvec = id_valid && (id_cd_ctrl == CD_ECALL);
        need_mepc  = id_valid && (id_cd_ctrl == CD_MRET);
        exp_ready  = 1'b1;
        for (int k = 0; k < NUM_STAGES; k++) begin
            if (need_rs1 && mdl_rd_write[k] && (mdl_rd[k] == id_rs1)) exp_ready = 1'b0;
            if (need_rs2 && mdl_rd_write[k] && (mdl_rd[k] == id_rs2)) exp_ready = 1'b0;
            if (need_mtvec && mdl_csr_write[k] && (mdl_csr[k] == MTVEC)) exp_ready = 1'b0;
            if (need_mepc && mdl_csr_write[k] && (mdl_csr[k] == MEPC)) exp_ready = 1'b0;
            if (need_mepc && mdl_ecall_write[k]) exp_ready = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int k = 0; k < NUM_STAGES; k++) begin
                mdl_rd_write[k]    <= 1'b0;
                mdl_csr_write[k]   <= 1'b0;
                mdl_ecall_write[k] <= 1'b0;
                mdl_rd[k]          <= '0;
                mdl_csr[k]         <= '0;
            end
        end else begin
            for (int k = NUM_STAGES - 1; k > 0; k--) begin
                mdl_rd_write[k]    <= mdl_rd_write[k-1];
                mdl_csr_write[k]   <= mdl_csr_write[k-1];
                mdl_ecall_write[k] <= mdl_ecall_write[k-1];
                mdl_rd[k]          <= mdl_rd[k-1];
                mdl_csr[k]         <= mdl_csr[k-1];
            end
            mdl_rd_write[0]    <= id_valid && exp_ready && writes_rd(id_wb_ctrl);
            mdl_csr_write[0]   <= id_valid && exp_ready && writes_csr(id_wb_ctrl);
            mdl_ecall_write[0] <= id_valid && exp_ready && (id_wb_ctrl == WB_ECALL);
            mdl_rd[0]          <= id_rd;
            mdl_csr[0]         <= id_csr;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        checks++;
        if (got !== expected) begin
            errors++;
            $display("mismatch %s: got %h expected %h at %0t", name, got, expected, $time);
        end
    endtask

    task automatic drive_instr(input cd_ctrl_e cd, input wb_ctrl_e wb, input reg_idx_t rd,
                               input reg_idx_t rs1, input reg_idx_t rs2, input csr_idx_t csr);
        @(negedge clk);
        id_valid   = 1'b1;
        id_cd_ctrl = cd;
        id_wb_ctrl = wb;
        id_rd      = rd;
        id_rs1     = rs1;
        id_rs2     = rs2;
        id_csr     = csr;
    endtask

    task automatic drive_idle(input int n);
        repeat (n) begin
            @(negedge clk);
            id_valid   = 1'b0;
            id_cd_ctrl = CD_NONE;
            id_wb_ctrl = WB_NONE;
        end
    endtask

    // counts the cycles the held instruction sees id_ready low
    task automatic wait_for_issue(input int exp_wait);
        int waited;
        waited = 0;
        #1;
        while (!id_ready && waited <= NUM_STAGES + 2) begin
            @(negedge clk);
            #1;
            waited++;
        end
        if (!id_ready) begin
            errors++;
            $display("instruction in ID was never accepted at %0t", $time);
        end
        check_value("id_ready_low_cycles", waited, exp_wait);
    endtask

    task automatic report_test(input string name, input int err_start);
        tests++;
        $display("%-26s %0d errors", name, errors - err_start);
    endtask

    task automatic branch_after_reset();
        int err_start;
        err_start = errors;
        check_value("id_ready", 32'(id_ready), 32'd1);
        for (int r = 0; r < 16; r++) begin
            drive_instr(CD_BRANCHES, WB_NONE, 4'd0, reg_idx_t'(r), reg_idx_t'(15 - r), MCAUSE);
            wait_for_issue(0);
        end
        drive_idle(NUM_STAGES + 1);
        report_test("branch_after_reset", err_start);
    endtask

    task automatic rd_writer_then_branch();
        int err_start;
        err_start = errors;
        drive_instr(CD_NONE, WB_EXE, 4'd5, 4'd0, 4'd0, MCAUSE);
        wait_for_issue(0);
        drive_instr(CD_BRANCHES, WB_NONE, 4'd0, 4'd1, 4'd5, MCAUSE);
        wait_for_issue(NUM_STAGES);
        drive_idle(NUM_STAGES + 1);
        drive_instr(CD_NONE, WB_NONE, 4'd5, 4'd0, 4'd0, MCAUSE);  // no write, no stall
        wait_for_issue(0);
        drive_instr(CD_BRANCHES, WB_NONE, 4'd0, 4'd1, 4'd5, MCAUSE);
        wait_for_issue(0);
        drive_idle(NUM_STAGES + 1);
        report_test("rd_writer_then_branch", err_start);
    endtask

    task automatic csr_writer_then_ecall();
        int err_start;
        err_start = errors;
        drive_instr(CD_NONE, WB_CSRRW, 4'd2, 4'd0, 4'd0, MTVEC);
        wait_for_issue(0);
        drive_instr(CD_ECALL, WB_ECALL, 4'd0, 4'd0, 4'd0, MSTATUS);
        wait_for_issue(NUM_STAGES);
        drive_idle(NUM_STAGES + 1);
        drive_instr(CD_NONE, WB_CSRRW, 4'd2, 4'd0, 4'd0, MEPC);
        wait_for_issue(0);
        drive_instr(CD_ECALL, WB_ECALL, 4'd0, 4'd0, 4'd0, MSTATUS);
        wait_for_issue(0);
        drive_idle(NUM_STAGES + 1);
        report_test("csr_writer_then_ecall", err_start);
    endtask

    task automatic mepc_writers_then_mret();
        int err_start;
        err_start = errors;
        drive_instr(CD_ECALL, WB_ECALL, 4'd0, 4'd0, 4'd0, MSTATUS);
        wait_for_issue(0);
        drive_instr(CD_MRET, WB_NONE, 4'd0, 4'd0, 4'd0, MSTATUS);
        wait_for_issue(NUM_STAGES);
        drive_idle(NUM_STAGES + 1);
        drive_instr(CD_NONE, WB_CSRRWI, 4'd7, 4'd0, 4'd0, MEPC);
        wait_for_issue(0);
        drive_instr(CD_MRET, WB_NONE, 4'd0, 4'd0, 4'd0, MSTATUS);
        wait_for_issue(NUM_STAGES);
        drive_idle(NUM_STAGES + 1);
        report_test("mepc_writers_then_mret", err_start);
    endtask

    task automatic jalr_after_gap();
        int err_start;
        err_start = errors;
        drive_instr(CD_NONE, WB_MEM, 4'd9, 4'd0, 4'd0, MCAUSE);
        wait_for_issue(0);
        drive_idle(1);  // writer already one slot ahead
        drive_instr(CD_JALR, WB_SNPC, 4'd1, 4'd9, 4'd0, MCAUSE);
        wait_for_issue(NUM_STAGES - 1);
        drive_idle(NUM_STAGES + 1);
        report_test("jalr_after_gap", err_start);
    endtask

    task automatic random_stream(input int count);
        int          err_start;
        int          issued;
        logic        held;
        logic [31:0] r_ctl;
        logic [31:0] r_fld;
        logic [31:0] v_cd;
        logic [31:0] v_wb;
        err_start = errors;
        issued    = 0;
        held      = 1'b0;
        while (issued < count) begin
            @(negedge clk);
            if (!held) begin
                r_ctl      = $random(seed);
                r_fld      = $random(seed);
                v_cd       = r_ctl % 32'd5;
                v_wb       = (r_ctl >> 8) % 32'd9;
                id_valid   = (r_ctl[31:30] != 2'b00);
                id_cd_ctrl = cd_ctrl_e'(v_cd[2:0]);
                id_wb_ctrl = wb_ctrl_e'(v_wb[3:0]);
                id_rd      = {1'b0, r_fld[2:0]};  // small index range for more hits
                id_rs1     = {1'b0, r_fld[6:4]};
                id_rs2     = {1'b0, r_fld[10:8]};
                id_csr     = csr_idx_t'({2'b00, r_fld[13:12]} + 4'd1);
            end
            #1;
            check_value("id_ready", 32'(id_ready), 32'(exp_ready));
            held = id_valid && !id_ready;
            if (id_valid && id_ready) issued++;
        end
        drive_idle(NUM_STAGES + 1);
        report_test("random_stream", err_start);
    endtask

    initial begin : watchdog
        cycles = 0;
        while (cycles < CYCLE_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        seed       = 32'h69598284;
        errors     = 0;
        checks     = 0;
        tests      = 0;
        rst_n      = 1'b0;
        id_valid   = 1'b0;
        id_cd_ctrl = CD_NONE;
        id_wb_ctrl = WB_NONE;
        id_rd      = '0;
        id_rs1     = '0;
        id_rs2     = '0;
        id_csr     = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        branch_after_reset();
        rd_writer_then_branch();
        csr_writer_then_ecall();
        mepc_writers_then_mret();
        jalr_after_gap();
        random_stream(200);
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
common/hazard_pkg.sv
hdl/read_demand_decode.sv
hdl/writer_slot.sv
hdl/stall_merge.sv
hdl/hazard_detector.sv
bench/hazard_detector_properties.sv
bench/hazard_detector_tb.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        ?= hazard_detector_tb
LINT_TOP   ?= hazard_detector
FILE_LIST  ?= list.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= TEST PASSED

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILE_LIST)

clean:
	rm -rf $(BUILD_DIR)
